// File: filelist.f
hdl/radio_ctrl_pkg.sv
hdl/misc_settings.sv
hdl/vita_timer.sv
hdl/readback_mux.sv
hdl/radio_ctrl_top.sv
verification/tb_clk_gen.sv
verification/radio_ctrl_checker.sv
verification/radio_ctrl_tb.sv

// File: Bender.yml
package:
  name: radio_ctrl

sources:
  - files:
      - hdl/radio_ctrl_pkg.sv
      - hdl/misc_settings.sv
      - hdl/vita_timer.sv
      - hdl/readback_mux.sv
      - hdl/radio_ctrl_top.sv
  - target: test
    files:
      - verification/tb_clk_gen.sv
      - verification/radio_ctrl_checker.sv
      - verification/radio_ctrl_tb.sv

// File: verification/radio_ctrl_tb.sv
// Radio control plane testbench
`timescale 1ns/1ps

module radio_ctrl_tb;

   // Tests need a few hundred cycles
   localparam int unsigned MAX_CYCLES = 2000;

   logic                         dsp_clk;
   logic                         por_rst;
   radio_ctrl_pkg::set_bus_t     set_bus;
   logic                         pps;
   logic                         run_rx;
   logic                         clk_status;
   logic                         link_up;
   radio_ctrl_pkg::rb_word_t     status;
   logic                         rb_stb;
   radio_ctrl_pkg::rb_addr_t     rb_addr;
   radio_ctrl_pkg::clock_ctrl_t  clock_ctrl;
   radio_ctrl_pkg::serdes_ctrl_t serdes_ctrl;
   radio_ctrl_pkg::adc_ctrl_t    adc_ctrl;
   logic                         phy_reset_n;
   radio_ctrl_pkg::led_t         leds;
   logic                         pps_int;
   logic                         rb_ack;
   radio_ctrl_pkg::rb_word_t     rb_data;

   int unsigned          cycles = 0;
   logic [31:0]          rng_state = 32'h4cd43590;
   radio_ctrl_pkg::led_t led_src = radio_ctrl_pkg::LED_SRC_RESET;
   radio_ctrl_pkg::led_t led_sw = '0;
   logic                 sync_seen = 1'b0;

   tb_clk_gen i_clk_gen (.dsp_clk(dsp_clk), .por_rst(por_rst));

   radio_ctrl_top i_dut (
      .dsp_clk       (dsp_clk),
      .por_rst       (por_rst),
      .set_i         (set_bus),
      .pps_i         (pps),
      .run_rx_i      (run_rx),
      .clk_status_i  (clk_status),
      .link_up_i     (link_up),
      .status_i      (status),
      .rb_stb_i      (rb_stb),
      .rb_addr_i     (rb_addr),
      .clock_ctrl_o  (clock_ctrl),
      .serdes_ctrl_o (serdes_ctrl),
      .adc_ctrl_o    (adc_ctrl),
      .phy_reset_n_o (phy_reset_n),
      .leds_o        (leds),
      .pps_int_o     (pps_int),
      .rb_ack_o      (rb_ack),
      .rb_data_o     (rb_data)
   );

   ////////////////////
   // Helpers

   task automatic abort_run();
      $display("test failed");
      $fatal(1, "Run stopped at the first failure");
   endtask

   always @(posedge dsp_clk) begin
      cycles <= cycles + 1;
      if (cycles >= MAX_CYCLES) begin
         $display("Timeout: tests did not finish within %0d cycles", MAX_CYCLES);
         abort_run();
      end
   end

   // Assertion failures of the bound checker end the run as well
   always @(negedge dsp_clk) begin
      if (i_dut.i_checker.fail_count != 0) begin
         $display("An assertion in radio_ctrl_checker failed");
         abort_run();
      end
   end

   task automatic check_value(input string name, input logic [63:0] got,
                              input logic [63:0] exp);
      if (got !== exp) begin
         $display("Mismatch at %0t: %s got %0h, expected %0h", $time, name, got, exp);
         abort_run();
      end
   endtask

   function automatic logic [31:0] rand_word();
      rng_state = rng_state ^ (rng_state << 13);
      rng_state = rng_state ^ (rng_state >> 17);
      rng_state = rng_state ^ (rng_state << 5);
      return rng_state;
   endfunction

   // Per bit choice between hardware status and software value
   function automatic radio_ctrl_pkg::led_t expected_leds();
      radio_ctrl_pkg::led_t hw;
      radio_ctrl_pkg::led_t mix;
      hw = '0;
      hw[3] = run_rx;
      hw[2] = clk_status;
      hw[1] = link_up && sync_seen;
      for (int i = 0; i < 8; i++)
         mix[i] = led_src[i] ? hw[i] : led_sw[i];
      return mix;
   endfunction

   task automatic write_setting(input radio_ctrl_pkg::set_addr_t addr,
                                input radio_ctrl_pkg::set_data_t data);
      @(posedge dsp_clk);
      set_bus <= '{stb: 1'b1, addr: addr, data: data};
      @(posedge dsp_clk);
      set_bus.stb <= 1'b0;
      @(negedge dsp_clk);
   endtask

   // at_cycle is the count that includes the sampling edge
   task automatic read_word(input radio_ctrl_pkg::rb_addr_t addr,
                            output radio_ctrl_pkg::rb_word_t data,
                            output int unsigned at_cycle);
      @(posedge dsp_clk);
      rb_stb  <= 1'b1;
      rb_addr <= addr;
      @(negedge dsp_clk);
      check_value("rb_ack_o", rb_ack, 1'b0);
      @(posedge dsp_clk);
      rb_stb <= 1'b0;
      @(negedge dsp_clk);
      check_value("rb_ack_o", rb_ack, 1'b1);
      data = rb_data;
      at_cycle = cycles;
      @(negedge dsp_clk);
      check_value("rb_ack_o", rb_ack, 1'b0);
   endtask

   ////////////////////
   // Directed tests

   task automatic test_reset_defaults();
      check_value("clock_ctrl_o", clock_ctrl, '0);
      check_value("serdes_ctrl_o", serdes_ctrl, '0);
      check_value("adc_ctrl_o", adc_ctrl, '0);
      check_value("phy_reset_n_o", phy_reset_n, 1'b1);
      check_value("leds_o", leds, expected_leds());
      check_value("pps_int_o", pps_int, 1'b0);
      check_value("rb_ack_o", rb_ack, 1'b0);
   endtask

   task automatic test_misc_registers();
      logic [31:0] r;
      for (int i = 0; i < 3; i++) begin
         r = rand_word();
         write_setting(radio_ctrl_pkg::SR_MISC + radio_ctrl_pkg::MISC_CLK, r);
         check_value("clock_ctrl_o", clock_ctrl, r[4:0]);
         r = rand_word();
         write_setting(radio_ctrl_pkg::SR_MISC + radio_ctrl_pkg::MISC_SER, r);
         check_value("serdes_ctrl_o", serdes_ctrl, r[3:0]);
         r = rand_word();
         write_setting(radio_ctrl_pkg::SR_MISC + radio_ctrl_pkg::MISC_ADC, r);
         check_value("adc_ctrl_o", adc_ctrl, r[3:0]);
         r = rand_word();
         write_setting(radio_ctrl_pkg::SR_MISC + radio_ctrl_pkg::MISC_PHY, r);
         check_value("phy_reset_n_o", phy_reset_n, !r[0]);
      end
      for (int i = 0; i < 4; i++) begin
         r = rand_word();
         led_sw  = r[7:0];
         led_src = r[15:8];
         write_setting(radio_ctrl_pkg::SR_MISC + radio_ctrl_pkg::MISC_LED_SW, led_sw);
         write_setting(radio_ctrl_pkg::SR_MISC + radio_ctrl_pkg::MISC_LED_SRC, led_src);
         r = rand_word();
         @(posedge dsp_clk);
         run_rx     <= r[0];
         clk_status <= r[1];
         link_up    <= r[2];
         @(negedge dsp_clk);
         check_value("leds_o", leds, expected_leds());
      end
   endtask

   task automatic test_readback();
      radio_ctrl_pkg::rb_addr_t zero_idx [10] = '{0, 1, 2, 3, 4, 5, 6, 7, 9, 13};
      radio_ctrl_pkg::rb_word_t word;
      logic [31:0]              r;
      int unsigned              at;
      read_word(radio_ctrl_pkg::RB_COMPAT, word, at);
      check_value("rb_data_o compat", word, 32'h0007_0003);
      r = rand_word();
      @(posedge dsp_clk);
      status <= r;
      read_word(radio_ctrl_pkg::RB_STATUS, word, at);
      check_value("rb_data_o status", word, r);
      foreach (zero_idx[i]) begin
         read_word(zero_idx[i], word, at);
         check_value("rb_data_o unused", word, '0);
      end
   endtask

   task automatic test_immediate_load();
      radio_ctrl_pkg::rb_word_t word;
      logic [31:0]              hi;
      logic [31:0]              lo;
      int unsigned              wr_cycle;
      int unsigned              at;
      hi = rand_word();
      lo = rand_word() & 32'h0FFF_FFFF;
      write_setting(radio_ctrl_pkg::SR_TIME64 + radio_ctrl_pkg::TIME_HI, hi);
      write_setting(radio_ctrl_pkg::SR_TIME64 + radio_ctrl_pkg::TIME_LO, lo);
      write_setting(radio_ctrl_pkg::SR_TIME64 + radio_ctrl_pkg::TIME_CTRL, 32'd1);
      wr_cycle = cycles;
      repeat (rand_word() % 8) @(posedge dsp_clk);
      read_word(radio_ctrl_pkg::RB_TIME_LO, word, at);
      check_value("rb_data_o time lo", word, lo + (at - wr_cycle) - 32'd1);
      read_word(radio_ctrl_pkg::RB_TIME_HI, word, at);
      check_value("rb_data_o time hi", word, hi);
   endtask

   task automatic test_pps_load();
      radio_ctrl_pkg::rb_word_t t0;
      radio_ctrl_pkg::rb_word_t t1;
      radio_ctrl_pkg::rb_word_t word;
      logic [31:0]              hi;
      logic [31:0]              lo;
      int unsigned              c0;
      int unsigned              c1;
      int unsigned              pulses;
      read_word(radio_ctrl_pkg::RB_TIME_LO, t0, c0);
      hi = rand_word();
      lo = rand_word() & 32'h0FFF_FFFF;
      write_setting(radio_ctrl_pkg::SR_TIME64 + radio_ctrl_pkg::TIME_HI, hi);
      write_setting(radio_ctrl_pkg::SR_TIME64 + radio_ctrl_pkg::TIME_LO, lo);
      write_setting(radio_ctrl_pkg::SR_TIME64 + radio_ctrl_pkg::TIME_CTRL, 32'd0);
      led_src = led_src | 8'h02;
      write_setting(radio_ctrl_pkg::SR_MISC + radio_ctrl_pkg::MISC_LED_SRC, led_src);
      @(posedge dsp_clk);
      link_up <= 1'b1;
      @(negedge dsp_clk);
      check_value("leds_o", leds, expected_leds());
      // Armed, so the count runs on
      read_word(radio_ctrl_pkg::RB_TIME_LO, t1, c1);
      check_value("rb_data_o time lo", t1, t0 + (c1 - c0));
      pulses = 0;
      for (int i = 0; i < 16; i++) begin
         @(posedge dsp_clk);
         pps <= (i < 5);
         @(negedge dsp_clk);
         if (pps_int)
            pulses++;
      end
      check_value("pps_int_o pulse count", pulses, 1);
      sync_seen = 1'b1;
      check_value("leds_o", leds, expected_leds());
      check_value("leds_o[1]", leds[1], 1'b1);
      read_word(radio_ctrl_pkg::RB_PPS_HI, word, c1);
      check_value("rb_data_o pps hi", word, hi);
      read_word(radio_ctrl_pkg::RB_PPS_LO, word, c1);
      check_value("rb_data_o pps lo", word, lo);
   endtask

   initial begin
      set_bus    = '0;
      pps        = 1'b0;
      run_rx     = 1'b1;
      clk_status = 1'b0;
      link_up    = 1'b1;
      status     = '0;
      rb_stb     = 1'b0;
      rb_addr    = '0;
      @(negedge dsp_clk);
      while (por_rst)
         @(negedge dsp_clk);
      test_reset_defaults();
      test_misc_registers();
      test_readback();
      test_immediate_load();
      test_pps_load();
      $display("test passed");
      $finish;
   end

endmodule

// File: verification/radio_ctrl_checker.sv
// Radio control plane assertions
`timescale 1ns/1ps

module radio_ctrl_checker (
   input logic                       dsp_clk,
   input logic                       por_rst,
   input logic                       pps_int_i,
   input logic                       rb_stb_i,
   input logic                       rb_ack_i,
   input radio_ctrl_pkg::vita_time_t vita_time_i,
   input logic                       load_now_i,
   input logic                       load_pps_i
);

   // Number of failed assertions so far
   int unsigned fail_count = 0;

   // PPS interrupt is a single cycle pulse
   pps_int_single: assert property (@(posedge dsp_clk) disable iff (por_rst)
      pps_int_i |=> !pps_int_i)
      else begin
         fail_count++;
         $error("pps_int_o stayed high for two cycles");
      end

   // Acknowledge is the strobe delayed by one cycle
   rb_ack_follows: assert property (@(posedge dsp_clk) disable iff (por_rst)
      rb_ack_i == $past(rb_stb_i))
      else begin
         fail_count++;
         $error("rb_ack_o does not follow rb_stb_i by one cycle");
      end

   // Free running count without a load
   time_increments: assert property (@(posedge dsp_clk) disable iff (por_rst)
      !(load_now_i || load_pps_i) |=> vita_time_i == $past(vita_time_i) + 64'd1)
      else begin
         fail_count++;
         $error("vita_time did not advance by one");
      end

endmodule

bind radio_ctrl_top radio_ctrl_checker i_checker (
   .dsp_clk     (dsp_clk),
   .por_rst     (por_rst),
   .pps_int_i   (pps_int_o),
   .rb_stb_i    (rb_stb_i),
   .rb_ack_i    (rb_ack_o),
   .vita_time_i (vita_time),
   .load_now_i  (i_timer.load_now),
   .load_pps_i  (i_timer.load_pps)
);

// File: verification/tb_clk_gen.sv
// Testbench clock and reset
`timescale 1ns/1ps

module tb_clk_gen (
   output logic dsp_clk,
   output logic por_rst
);

   // 20 ns period
   initial begin
      dsp_clk = 1'b0;
      forever #10 dsp_clk = ~dsp_clk;
   end

   // Reset held over the first two rising edges
   initial begin
      por_rst = 1'b1;
      repeat (2) @(posedge dsp_clk);
      por_rst <= 1'b0;
   end

endmodule

// File: hdl/radio_ctrl_top.sv
// Radio control plane top
`timescale 1ns/1ps

module radio_ctrl_top (
   input  logic                         dsp_clk,
   input  logic                         por_rst,
   input  radio_ctrl_pkg::set_bus_t     set_i,
   input  logic                         pps_i,
   input  logic                         run_rx_i,
   input  logic                         clk_status_i,
   input  logic                         link_up_i,
   input  radio_ctrl_pkg::rb_word_t     status_i,
   input  logic                         rb_stb_i,
   input  radio_ctrl_pkg::rb_addr_t     rb_addr_i,
   output radio_ctrl_pkg::clock_ctrl_t  clock_ctrl_o,
   output radio_ctrl_pkg::serdes_ctrl_t serdes_ctrl_o,
   output radio_ctrl_pkg::adc_ctrl_t    adc_ctrl_o,
   output logic                         phy_reset_n_o,
   output radio_ctrl_pkg::led_t         leds_o,
   output logic                         pps_int_o,
   output logic                         rb_ack_o,
   output radio_ctrl_pkg::rb_word_t     rb_data_o
);

   radio_ctrl_pkg::vita_time_t vita_time;
   radio_ctrl_pkg::vita_time_t vita_time_pps;
   logic                       good_sync;

   ////////////////////
   // Settings registers

   misc_settings #(.BASE(radio_ctrl_pkg::SR_MISC)) i_misc (
      .dsp_clk       (dsp_clk),
      .por_rst       (por_rst),
      .set_i         (set_i),
      .run_rx_i      (run_rx_i),
      .clk_status_i  (clk_status_i),
      .link_up_i     (link_up_i),
      .good_sync_i   (good_sync),
      .clock_ctrl_o  (clock_ctrl_o),
      .serdes_ctrl_o (serdes_ctrl_o),
      .adc_ctrl_o    (adc_ctrl_o),
      .phy_reset_n_o (phy_reset_n_o),
      .leds_o        (leds_o)
   );

   ////////////////////
   // VITA time

   vita_timer #(.BASE(radio_ctrl_pkg::SR_TIME64)) i_timer (
      .dsp_clk         (dsp_clk),
      .por_rst         (por_rst),
      .set_i           (set_i),
      .pps_i           (pps_i),
      .vita_time_o     (vita_time),
      .vita_time_pps_o (vita_time_pps),
      .pps_int_o       (pps_int_o),
      .good_sync_o     (good_sync)
   );

   ////////////////////
   // Readback, compat 7.3

   readback_mux #(
      .COMPAT_MAJOR (16'd7),
      .COMPAT_MINOR (16'd3)
   ) i_readback (
      .dsp_clk         (dsp_clk),
      .por_rst         (por_rst),
      .rb_stb_i        (rb_stb_i),
      .rb_addr_i       (rb_addr_i),
      .status_i        (status_i),
      .vita_time_i     (vita_time),
      .vita_time_pps_i (vita_time_pps),
      .rb_ack_o        (rb_ack_o),
      .rb_data_o       (rb_data_o)
   );

endmodule

// File: hdl/readback_mux.sv
// Status readback mux
`timescale 1ns/1ps

module readback_mux #(
   parameter logic [15:0] COMPAT_MAJOR = 16'd0,
   parameter logic [15:0] COMPAT_MINOR = 16'd0
) (
   input  logic                       dsp_clk,
   input  logic                       por_rst,
   input  logic                       rb_stb_i,
   input  radio_ctrl_pkg::rb_addr_t   rb_addr_i,
   input  radio_ctrl_pkg::rb_word_t   status_i,
   input  radio_ctrl_pkg::vita_time_t vita_time_i,
   input  radio_ctrl_pkg::vita_time_t vita_time_pps_i,
   output logic                       rb_ack_o,
   output radio_ctrl_pkg::rb_word_t   rb_data_o
);

   radio_ctrl_pkg::rb_word_t sel_word;

   // Unused indices, the old irq word included, read zero
   always_comb begin
      case (rb_addr_i)
         radio_ctrl_pkg::RB_STATUS:  sel_word = status_i;
         radio_ctrl_pkg::RB_TIME_HI: sel_word = vita_time_i[63:32];
         radio_ctrl_pkg::RB_TIME_LO: sel_word = vita_time_i[31:0];
         radio_ctrl_pkg::RB_COMPAT:  sel_word = {COMPAT_MAJOR, COMPAT_MINOR};
         radio_ctrl_pkg::RB_PPS_HI:  sel_word = vita_time_pps_i[63:32];
         radio_ctrl_pkg::RB_PPS_LO:  sel_word = vita_time_pps_i[31:0];
         default:                    sel_word = '0;
      endcase
   end

   ////////////////////
   // Acknowledge and data

   always_ff @(posedge dsp_clk) begin
      if (por_rst)
         rb_ack_o <= 1'b0;
      else
         rb_ack_o <= rb_stb_i;
   end

   // Word is held until the next strobe
   always_ff @(posedge dsp_clk) begin
      if (rb_stb_i)
         rb_data_o <= sel_word;
   end

endmodule

// File: hdl/vita_timer.sv
// VITA time counter with PPS sync
`timescale 1ns/1ps

module vita_timer #(
   parameter radio_ctrl_pkg::set_addr_t BASE = radio_ctrl_pkg::SR_TIME64
) (
   input  logic                       dsp_clk,
   input  logic                       por_rst,
   input  radio_ctrl_pkg::set_bus_t   set_i,
   input  logic                       pps_i,
   output radio_ctrl_pkg::vita_time_t vita_time_o,
   output radio_ctrl_pkg::vita_time_t vita_time_pps_o,
   output logic                       pps_int_o,
   output logic                       good_sync_o
);

   localparam radio_ctrl_pkg::set_addr_t ADDR_HI   = BASE + radio_ctrl_pkg::TIME_HI;
   localparam radio_ctrl_pkg::set_addr_t ADDR_LO   = BASE + radio_ctrl_pkg::TIME_LO;
   localparam radio_ctrl_pkg::set_addr_t ADDR_CTRL = BASE + radio_ctrl_pkg::TIME_CTRL;

   radio_ctrl_pkg::set_data_t  load_hi;
   radio_ctrl_pkg::set_data_t  load_lo;
   radio_ctrl_pkg::vita_time_t vita_time;
   radio_ctrl_pkg::vita_time_t next_time;
   logic                       armed;
   logic [1:0]                 pps_sync;
   logic                       pps_dly;
   logic                       pps_edge;
   logic                       wr_ctrl;
   logic                       load_now;
   logic                       load_pps;

   ////////////////////
   // Time load registers

   assign wr_ctrl  = set_i.stb && (set_i.addr == ADDR_CTRL);
   assign load_now = wr_ctrl && set_i.data[0];

   always_ff @(posedge dsp_clk) begin
      if (por_rst) begin
         load_hi <= '0;
         load_lo <= '0;
      end else if (set_i.stb) begin
         if (set_i.addr == ADDR_HI)
            load_hi <= set_i.data;
         if (set_i.addr == ADDR_LO)
            load_lo <= set_i.data;
      end
   end

   ////////////////////
   // PPS synchronizer and edge detect

   always_ff @(posedge dsp_clk) begin
      if (por_rst) begin
         pps_sync <= 2'b00;
         pps_dly  <= 1'b0;
      end else begin
         pps_sync <= {pps_sync[0], pps_i};
         pps_dly  <= pps_sync[1];
      end
   end

   assign pps_edge = pps_sync[1] & ~pps_dly;
   assign load_pps = pps_edge & armed;

   // Software load wins over a PPS load at the same edge
   always_comb begin
      if (load_now || load_pps)
         next_time = {load_hi, load_lo};
      else
         next_time = vita_time + 64'd1;
   end

   ////////////////////
   // Counter, arm and capture

   always_ff @(posedge dsp_clk) begin
      if (por_rst) begin
         vita_time       <= '0;
         vita_time_pps_o <= '0;
         armed           <= 1'b0;
         good_sync_o     <= 1'b0;
         pps_int_o       <= 1'b0;
      end else begin
         vita_time <= next_time;
         pps_int_o <= pps_edge;
         if (pps_edge)
            vita_time_pps_o <= next_time;
         // A control write arms when bit 0 is clear, else disarms
         if (wr_ctrl)
            armed <= ~set_i.data[0];
         else if (load_pps)
            armed <= 1'b0;
         if (load_pps)
            good_sync_o <= 1'b1;
      end
   end

   assign vita_time_o = vita_time;

endmodule

// File: hdl/misc_settings.sv
// Misc settings and LED mix
`timescale 1ns/1ps

module misc_settings #(
   parameter radio_ctrl_pkg::set_addr_t BASE = radio_ctrl_pkg::SR_MISC
) (
   input  logic                         dsp_clk,
   input  logic                         por_rst,
   input  radio_ctrl_pkg::set_bus_t     set_i,
   input  logic                         run_rx_i,
   input  logic                         clk_status_i,
   input  logic                         link_up_i,
   input  logic                         good_sync_i,
   output radio_ctrl_pkg::clock_ctrl_t  clock_ctrl_o,
   output radio_ctrl_pkg::serdes_ctrl_t serdes_ctrl_o,
   output radio_ctrl_pkg::adc_ctrl_t    adc_ctrl_o,
   output logic                         phy_reset_n_o,
   output radio_ctrl_pkg::led_t         leds_o
);

   // Absolute register addresses
   localparam radio_ctrl_pkg::set_addr_t ADDR_CLK     = BASE + radio_ctrl_pkg::MISC_CLK;
   localparam radio_ctrl_pkg::set_addr_t ADDR_SER     = BASE + radio_ctrl_pkg::MISC_SER;
   localparam radio_ctrl_pkg::set_addr_t ADDR_ADC     = BASE + radio_ctrl_pkg::MISC_ADC;
   localparam radio_ctrl_pkg::set_addr_t ADDR_LED_SW  = BASE + radio_ctrl_pkg::MISC_LED_SW;
   localparam radio_ctrl_pkg::set_addr_t ADDR_PHY     = BASE + radio_ctrl_pkg::MISC_PHY;
   localparam radio_ctrl_pkg::set_addr_t ADDR_LED_SRC = BASE + radio_ctrl_pkg::MISC_LED_SRC;

   radio_ctrl_pkg::clock_ctrl_t  clock_reg;
   radio_ctrl_pkg::serdes_ctrl_t serdes_reg;
   radio_ctrl_pkg::adc_ctrl_t    adc_reg;
   radio_ctrl_pkg::led_t         led_sw;
   radio_ctrl_pkg::led_t         led_src;
   radio_ctrl_pkg::led_t         led_hw;
   logic                         phy_reset;

   ////////////////////
   // Register file

   always_ff @(posedge dsp_clk) begin
      if (por_rst) begin
         clock_reg  <= '0;
         serdes_reg <= '0;
         adc_reg    <= '0;
         led_sw     <= '0;
         phy_reset  <= 1'b0;
         led_src    <= radio_ctrl_pkg::LED_SRC_RESET;
      end else if (set_i.stb) begin
         case (set_i.addr)
            ADDR_CLK:     clock_reg  <= radio_ctrl_pkg::clock_ctrl_t'(set_i.data[4:0]);
            ADDR_SER:     serdes_reg <= radio_ctrl_pkg::serdes_ctrl_t'(set_i.data[3:0]);
            ADDR_ADC:     adc_reg    <= radio_ctrl_pkg::adc_ctrl_t'(set_i.data[3:0]);
            ADDR_LED_SW:  led_sw     <= set_i.data[7:0];
            ADDR_PHY:     phy_reset  <= set_i.data[0];
            ADDR_LED_SRC: led_src    <= set_i.data[7:0];
            default: begin
            end
         endcase
      end
   end

   assign clock_ctrl_o  = clock_reg;
   assign serdes_ctrl_o = serdes_reg;
   assign adc_ctrl_o    = adc_reg;

   // PHY reset pin is active low
   assign phy_reset_n_o = ~phy_reset;

   ////////////////////
   // LED mix

   // Bit 4 would be run_tx, there is no transmit path here
   assign led_hw = {3'b000, 1'b0, run_rx_i, clk_status_i, link_up_i & good_sync_i, 1'b0};

   // A set source bit hands the LED to hardware
   assign leds_o = (led_src & led_hw) | (~led_src & led_sw);

endmodule

// File: hdl/radio_ctrl_pkg.sv
// Radio control plane definitions

package radio_ctrl_pkg;

   ////////////////////
   // Widths and base types

   typedef logic [7:0]  set_addr_t;
   typedef logic [31:0] set_data_t;
   typedef logic [63:0] vita_time_t;
   typedef logic [7:0]  led_t;
   typedef logic [3:0]  rb_addr_t;
   typedef logic [31:0] rb_word_t;

   // One write on the settings bus
   typedef struct packed {
      logic      stb;
      set_addr_t addr;
      set_data_t data;
   } set_bus_t;

   // Clock generator controls, SR_MISC+0 bits 4:0
   typedef struct packed {
      logic       clock_ready;
      logic [1:0] clk_en;
      logic [1:0] clk_sel;
   } clock_ctrl_t;

   // SERDES controls, SR_MISC+1 bits 3:0
   typedef struct packed {
      logic enable;
      logic prbsen;
      logic loopen;
      logic rx_en;
   } serdes_ctrl_t;

   // ADC controls, SR_MISC+2 bits 3:0
   typedef struct packed {
      logic oe_a;
      logic on_a;
      logic oe_b;
      logic on_b;
   } adc_ctrl_t;

   ////////////////////
   // Settings address map

   localparam set_addr_t SR_MISC   = 8'd0;
   localparam set_addr_t SR_TIME64 = 8'd10;

   localparam set_addr_t MISC_CLK     = 8'd0;
   localparam set_addr_t MISC_SER     = 8'd1;
   localparam set_addr_t MISC_ADC     = 8'd2;
   localparam set_addr_t MISC_LED_SW  = 8'd3;
   localparam set_addr_t MISC_PHY     = 8'd4;
   localparam set_addr_t MISC_LED_SRC = 8'd6;

   localparam set_addr_t TIME_HI   = 8'd0;
   localparam set_addr_t TIME_LO   = 8'd1;
   localparam set_addr_t TIME_CTRL = 8'd2;

   // Status, clock and link LEDs under hardware control
   localparam led_t LED_SRC_RESET = 8'h1E;

   ////////////////////
   // Readback word indices

   localparam rb_addr_t RB_STATUS  = 4'd8;
   localparam rb_addr_t RB_TIME_HI = 4'd10;
   localparam rb_addr_t RB_TIME_LO = 4'd11;
   localparam rb_addr_t RB_COMPAT  = 4'd12;
   localparam rb_addr_t RB_PPS_HI  = 4'd14;
   localparam rb_addr_t RB_PPS_LO  = 4'd15;

endpackage
